// ==== source/alu_data_pkg.sv ====
`default_nettype none

package alu_data_pkg;

	// Operand and result width
	localparam int DATA_W = 32;

	// Shift amount covers 0 to DATA_W-1
	localparam int SHAMT_W = 5;

	// Ripple-carry block size inside the carry-select adder
	localparam int CSEL_BLOCK_W = 4;

	typedef logic [DATA_W-1:0] word_t;

	typedef logic [SHAMT_W-1:0] shamt_t;

endpackage

`default_nettype wire

// ==== source/alu_op_pkg.sv ====
`default_nettype none

package alu_op_pkg;

	localparam int OP_W = 3;

	// Code 7 is unused and yields a zero result
	typedef enum logic [OP_W-1:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_NOT = 3'd4,
		OP_SLL = 3'd5,
		OP_SRA = 3'd6
	} alu_op_t;

endpackage

`default_nettype wire

// ==== source/alu_operand_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface alu_operand_if;

	alu_data_pkg::word_t a;
	alu_data_pkg::word_t b;
	alu_data_pkg::shamt_t shamt;
	alu_op_pkg::alu_op_t op;
	logic valid;

	modport source (
		output a,
		output b,
		output shamt,
		output op,
		output valid
	);

	modport sink (
		input a,
		input b,
		input shamt,
		input op,
		input valid
	);

endinterface

`default_nettype wire

// ==== source/add_sub_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module add_sub_unit (
	alu_operand_if.sink ops,
	output alu_data_pkg::word_t arith_result,
	output logic lt,
	output logic ne
);

	// One ripple-carry block, returns {carry out, sum}
	function automatic logic [alu_data_pkg::CSEL_BLOCK_W:0] ripple_add(
		input logic [alu_data_pkg::CSEL_BLOCK_W-1:0] x,
		input logic [alu_data_pkg::CSEL_BLOCK_W-1:0] y,
		input logic cin
	);
		logic [alu_data_pkg::CSEL_BLOCK_W-1:0] s;
		logic c;
		c = cin;
		for (int i = 0; i < alu_data_pkg::CSEL_BLOCK_W; i++) begin
			s[i] = x[i] ^ y[i] ^ c;
			c = (x[i] & y[i]) | ((x[i] ^ y[i]) & c);
		end
		return {c, s};
	endfunction

	logic is_sub;
	alu_data_pkg::word_t b_eff;
	alu_data_pkg::word_t sum;

	// Carry into each block, block 0 takes the subtract carry
	logic [alu_data_pkg::DATA_W / alu_data_pkg::CSEL_BLOCK_W - 1:0] carry;

	logic sign_a;
	logic sign_b;
	logic sign_d;
	logic both_pos_neg;
	logic neg_pos;
	logic both_neg_neg;
	logic lt_raw;
	logic ne_raw;

	assign is_sub = (ops.op == alu_op_pkg::OP_SUB);

	// Subtract as a + ~b + 1
	assign b_eff = is_sub ? ~ops.b : ops.b;
	assign carry[0] = is_sub;

	genvar g;
	generate
		for (g = 0; g < alu_data_pkg::DATA_W / alu_data_pkg::CSEL_BLOCK_W; g++) begin : g_csel
			logic [alu_data_pkg::CSEL_BLOCK_W:0] with_c0;
			logic [alu_data_pkg::CSEL_BLOCK_W:0] with_c1;

			// Both candidate sums ready before the carry arrives
			assign with_c0 = ripple_add(
				ops.a[g*alu_data_pkg::CSEL_BLOCK_W +: alu_data_pkg::CSEL_BLOCK_W],
				b_eff[g*alu_data_pkg::CSEL_BLOCK_W +: alu_data_pkg::CSEL_BLOCK_W],
				1'b0
			);
			assign with_c1 = ripple_add(
				ops.a[g*alu_data_pkg::CSEL_BLOCK_W +: alu_data_pkg::CSEL_BLOCK_W],
				b_eff[g*alu_data_pkg::CSEL_BLOCK_W +: alu_data_pkg::CSEL_BLOCK_W],
				1'b1
			);

			assign sum[g*alu_data_pkg::CSEL_BLOCK_W +: alu_data_pkg::CSEL_BLOCK_W] =
				carry[g] ? with_c1[alu_data_pkg::CSEL_BLOCK_W-1:0]
				         : with_c0[alu_data_pkg::CSEL_BLOCK_W-1:0];

			if (g < alu_data_pkg::DATA_W / alu_data_pkg::CSEL_BLOCK_W - 1) begin : g_carry
				assign carry[g+1] = carry[g] ? with_c1[alu_data_pkg::CSEL_BLOCK_W]
				                             : with_c0[alu_data_pkg::CSEL_BLOCK_W];
			end
		end
	endgenerate

	assign arith_result = sum;

	// Signed less-than from the operand signs and the difference sign
	assign sign_a = ops.a[alu_data_pkg::DATA_W-1];
	assign sign_b = ops.b[alu_data_pkg::DATA_W-1];
	assign sign_d = sum[alu_data_pkg::DATA_W-1];

	assign both_pos_neg = ~sign_a & ~sign_b & sign_d;
	assign neg_pos = sign_a & ~sign_b;
	assign both_neg_neg = sign_a & sign_b & sign_d;
	assign lt_raw = both_pos_neg | neg_pos | both_neg_neg;

	// Any nonzero difference bit
	assign ne_raw = |sum;

	// Flags only mean something for a subtract
	assign lt = is_sub & lt_raw;
	assign ne = is_sub & ne_raw;

endmodule

`default_nettype wire

// ==== source/logic_shift_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module logic_shift_unit (
	alu_operand_if.sink ops,
	output alu_data_pkg::word_t logic_result
);

	alu_data_pkg::word_t and_res;
	alu_data_pkg::word_t or_res;
	alu_data_pkg::word_t not_res;

	alu_data_pkg::word_t sll_16;
	alu_data_pkg::word_t sll_8;
	alu_data_pkg::word_t sll_4;
	alu_data_pkg::word_t sll_2;
	alu_data_pkg::word_t sll_1;

	alu_data_pkg::word_t sra_16;
	alu_data_pkg::word_t sra_8;
	alu_data_pkg::word_t sra_4;
	alu_data_pkg::word_t sra_2;
	alu_data_pkg::word_t sra_1;

	assign and_res = ops.a & ops.b;
	assign or_res = ops.a | ops.b;
	assign not_res = ~ops.a;

	// Left logical, largest stage first
	assign sll_16 = ops.shamt[4] ? {ops.a[15:0], 16'b0} : ops.a;
	assign sll_8 = ops.shamt[3] ? {sll_16[23:0], 8'b0} : sll_16;
	assign sll_4 = ops.shamt[2] ? {sll_8[27:0], 4'b0} : sll_8;
	assign sll_2 = ops.shamt[1] ? {sll_4[29:0], 2'b0} : sll_4;
	assign sll_1 = ops.shamt[0] ? {sll_2[30:0], 1'b0} : sll_2;

	// Right arithmetic, sign bit fills from the top
	assign sra_16 = ops.shamt[4] ? {{16{ops.a[31]}}, ops.a[31:16]} : ops.a;
	assign sra_8 = ops.shamt[3] ? {{8{sra_16[31]}}, sra_16[31:8]} : sra_16;
	assign sra_4 = ops.shamt[2] ? {{4{sra_8[31]}}, sra_8[31:4]} : sra_8;
	assign sra_2 = ops.shamt[1] ? {{2{sra_4[31]}}, sra_4[31:2]} : sra_4;
	assign sra_1 = ops.shamt[0] ? {sra_2[31], sra_2[31:1]} : sra_2;

	always_comb begin
		case (ops.op)
			alu_op_pkg::OP_AND: begin
				logic_result = and_res;
			end
			alu_op_pkg::OP_OR: begin
				logic_result = or_res;
			end
			alu_op_pkg::OP_NOT: begin
				logic_result = not_res;
			end
			alu_op_pkg::OP_SLL: begin
				logic_result = sll_1;
			end
			alu_op_pkg::OP_SRA: begin
				logic_result = sra_1;
			end
			// Arithmetic ops and the spare code
			default: begin
				logic_result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/result_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_stage (
	input wire logic clk,
	input wire logic clr,
	alu_operand_if.sink ops,
	input wire alu_data_pkg::word_t arith_result,
	input wire alu_data_pkg::word_t logic_result,
	input wire logic lt_in,
	input wire logic ne_in,
	output alu_data_pkg::word_t result,
	output logic lt,
	output logic ne,
	output logic out_valid
);

	alu_data_pkg::word_t sel_result;

	// Pick the unit that owns this op
	always_comb begin
		case (ops.op)
			alu_op_pkg::OP_ADD,
			alu_op_pkg::OP_SUB: begin
				sel_result = arith_result;
			end
			alu_op_pkg::OP_AND,
			alu_op_pkg::OP_OR,
			alu_op_pkg::OP_NOT,
			alu_op_pkg::OP_SLL,
			alu_op_pkg::OP_SRA: begin
				sel_result = logic_result;
			end
			default: begin
				sel_result = '0;
			end
		endcase
	end

	// Valid pulse follows the strobe by one cycle
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= ops.valid;
		end
	end

	// Outputs hold between accepted operations
	always_ff @(posedge clk or posedge clr) begin
		if (clr) begin
			result <= '0;
			lt <= 1'b0;
			ne <= 1'b0;
		end else if (ops.valid) begin
			result <= sel_result;
			lt <= lt_in;
			ne <= ne_in;
		end
	end

endmodule

`default_nettype wire

// ==== source/alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_top (
	input wire logic clk,
	input wire logic clr,
	input wire logic in_valid,
	input wire alu_op_pkg::alu_op_t op,
	input wire alu_data_pkg::word_t a,
	input wire alu_data_pkg::word_t b,
	input wire alu_data_pkg::shamt_t shamt,
	output alu_data_pkg::word_t result,
	output logic lt,
	output logic ne,
	output logic out_valid
);

	alu_data_pkg::word_t arith_result;
	alu_data_pkg::word_t logic_result;
	logic lt_comb;
	logic ne_comb;

	alu_operand_if ops ();

	// Operand bundle shared by all three units
	assign ops.a = a;
	assign ops.b = b;
	assign ops.shamt = shamt;
	assign ops.op = op;
	assign ops.valid = in_valid;

	add_sub_unit u_add_sub (
		.ops          (ops.sink),
		.arith_result (arith_result),
		.lt           (lt_comb),
		.ne           (ne_comb)
	);

	logic_shift_unit u_logic_shift (
		.ops          (ops.sink),
		.logic_result (logic_result)
	);

	// Single register stage
	result_stage u_result (
		.clk          (clk),
		.clr          (clr),
		.ops          (ops.sink),
		.arith_result (arith_result),
		.logic_result (logic_result),
		.lt_in        (lt_comb),
		.ne_in        (ne_comb),
		.result       (result),
		.lt           (lt),
		.ne           (ne),
		.out_valid    (out_valid)
	);

endmodule

`default_nettype wire

// ==== bench/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Expected result and flags of one operation
function automatic void alu_ref(
	input alu_op_pkg::alu_op_t op,
	input alu_data_pkg::word_t a,
	input alu_data_pkg::word_t b,
	input alu_data_pkg::shamt_t shamt,
	output alu_data_pkg::word_t res,
	output logic lt,
	output logic ne
);
	res = '0;
	lt = 1'b0;
	ne = 1'b0;
	case (op)
		alu_op_pkg::OP_ADD: begin
			res = a + b;
		end
		alu_op_pkg::OP_SUB: begin
			res = a - b;
			// Signed compare, flags only for a subtract
			lt = ($signed(a) < $signed(b));
			ne = (a != b);
		end
		alu_op_pkg::OP_AND: begin
			res = a & b;
		end
		alu_op_pkg::OP_OR: begin
			res = a | b;
		end
		alu_op_pkg::OP_NOT: begin
			res = ~a;
		end
		alu_op_pkg::OP_SLL: begin
			res = a << shamt;
		end
		alu_op_pkg::OP_SRA: begin
			res = alu_data_pkg::word_t'($signed(a) >>> shamt);
		end
		default: begin
			res = '0;
		end
	endcase
endfunction

// Full-period LCG modulo 2^32
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// ==== bench/alu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_tb;

	`include "alu_model.svh"

	// About 820 operations, 150 idle cycles and reset, with margin
	localparam int MAX_CYCLES = 2000;
	localparam logic [31:0] SEED = 32'd65;

	typedef struct {
		string name;
		alu_data_pkg::word_t result;
		logic lt;
		logic ne;
		int issue_cycle;
	} exp_t;

	logic clk;
	logic clr;
	logic in_valid;
	alu_op_pkg::alu_op_t op;
	alu_data_pkg::word_t a;
	alu_data_pkg::word_t b;
	alu_data_pkg::shamt_t shamt;
	alu_data_pkg::word_t result;
	logic lt;
	logic ne;
	logic out_valid;

	exp_t exp_q [$];
	exp_t cur;
	alu_data_pkg::word_t last_result;
	logic last_lt;
	logic last_ne;
	logic [31:0] rng;
	int cycles = 0;

	// Signed and unsigned limits
	alu_data_pkg::word_t limit_val [6] = '{32'h0000_0000, 32'h0000_0001, 32'h7FFF_FFFF,
		32'h8000_0000, 32'h8000_0001, 32'hFFFF_FFFF};

	alu_top dut0 (
		.clk       (clk),
		.clr       (clr),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.shamt     (shamt),
		.result    (result),
		.lt        (lt),
		.ne        (ne),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input alu_data_pkg::word_t exp,
		input alu_data_pkg::word_t act);
		if (exp !== act) begin
			abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// Two LCG steps, upper halves only
	function automatic alu_data_pkg::word_t rand_word();
		logic [15:0] hi;
		rng = lcg_next(rng);
		hi = rng[31:16];
		rng = lcg_next(rng);
		return {hi, rng[31:16]};
	endfunction

	task automatic issue_op(input string name, input alu_op_pkg::alu_op_t code,
		input alu_data_pkg::word_t x, input alu_data_pkg::word_t y,
		input alu_data_pkg::shamt_t s);
		exp_t e;
		alu_data_pkg::word_t r;
		logic l;
		logic n;
		@(negedge clk);
		in_valid = 1'b1;
		op = code;
		a = x;
		b = y;
		shamt = s;
		alu_ref(code, x, y, s, r, l, n);
		e.name = name;
		e.result = r;
		e.lt = l;
		e.ne = n;
		e.issue_cycle = cycles;
		exp_q.push_back(e);
	endtask

	// Junk on the operands while nothing is accepted
	task automatic idle_cycle();
		@(negedge clk);
		in_valid = 1'b0;
		a = rand_word();
		b = rand_word();
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			abort_run("Timeout: the test did not finish within the cycle limit");
		end
	end

	always @(negedge clk) begin
		if (!clr) begin
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("out_valid was high with no operation outstanding");
				end else begin
					cur = exp_q.pop_front();
					if (cycles != cur.issue_cycle + 1) begin
						abort_run($sformatf("%s: result came %0d cycles after issue",
							cur.name, cycles - cur.issue_cycle));
					end
					check_word(cur.name, cur.result, result);
					check_flag({cur.name, "_lt"}, cur.lt, lt);
					check_flag({cur.name, "_ne"}, cur.ne, ne);
					last_result = cur.result;
					last_lt = cur.lt;
					last_ne = cur.ne;
				end
			end else begin
				check_word("hold_result", last_result, result);
				check_flag("hold_lt", last_lt, lt);
				check_flag("hold_ne", last_ne, ne);
			end
		end
	end

	initial begin
		alu_data_pkg::word_t x;
		alu_data_pkg::word_t y;
		alu_data_pkg::word_t z;
		int gap;
		rng = SEED;
		last_result = '0;
		last_lt = 1'b0;
		last_ne = 1'b0;
		clr = 1'b1;
		in_valid = 1'b0;
		op = alu_op_pkg::OP_ADD;
		a = '0;
		b = '0;
		shamt = '0;
		repeat (8) begin
			@(negedge clk);
			check_flag("reset_out_valid", 1'b0, out_valid);
			check_word("reset_result", '0, result);
			check_flag("reset_lt", 1'b0, lt);
			check_flag("reset_ne", 1'b0, ne);
		end
		clr = 1'b0;

		for (int i = 0; i < 200; i++) begin
			x = rand_word();
			y = rand_word();
			issue_op("add_random", alu_op_pkg::OP_ADD, x, y, '0);
		end
		for (int i = 0; i < 200; i++) begin
			x = rand_word();
			y = rand_word();
			issue_op("sub_random", alu_op_pkg::OP_SUB, x, y, '0);
		end

		// Wrap cases, equal operands and mixed signs
		foreach (limit_val[i]) begin
			foreach (limit_val[j]) begin
				issue_op("add_limit", alu_op_pkg::OP_ADD, limit_val[i], limit_val[j], '0);
				issue_op("sub_limit", alu_op_pkg::OP_SUB, limit_val[i], limit_val[j], '0);
			end
		end

		// Flags drop again on the add that follows
		for (int i = 0; i < 30; i++) begin
			x = rand_word();
			y = (i % 5 == 0) ? x : rand_word();
			issue_op("cmp_sub", alu_op_pkg::OP_SUB, x, y, '0);
			issue_op("cmp_add", alu_op_pkg::OP_ADD, x, y, '0);
		end

		for (int i = 0; i < 20; i++) begin
			x = rand_word();
			y = rand_word();
			issue_op("and_random", alu_op_pkg::OP_AND, x, y, '0);
			issue_op("or_random", alu_op_pkg::OP_OR, x, y, '0);
			issue_op("not_random", alu_op_pkg::OP_NOT, x, y, '0);
		end
		issue_op("unused_op", alu_op_pkg::alu_op_t'(3'd7), 32'hFFFF_FFFF, 32'h1234_5678, '1);
		issue_op("unused_op", alu_op_pkg::alu_op_t'(3'd7), rand_word(), rand_word(), '0);

		for (int s = 0; s < 32; s++) begin
			issue_op("sll_neg", alu_op_pkg::OP_SLL, 32'hC3A5_9E71, '0, alu_data_pkg::shamt_t'(s));
			issue_op("sra_neg", alu_op_pkg::OP_SRA, 32'hC3A5_9E71, '0, alu_data_pkg::shamt_t'(s));
			issue_op("sll_pos", alu_op_pkg::OP_SLL, 32'h4B1D_0F35, '0, alu_data_pkg::shamt_t'(s));
			issue_op("sra_pos", alu_op_pkg::OP_SRA, 32'h4B1D_0F35, '0, alu_data_pkg::shamt_t'(s));
		end

		// Random mix, gaps of zero to three idle cycles
		for (int i = 0; i < 100; i++) begin
			z = rand_word();
			gap = int'(z[31:30]);
			repeat (gap) idle_cycle();
			x = rand_word();
			y = rand_word();
			issue_op("stream_mix", alu_op_pkg::alu_op_t'(z[2:0]), x, y, z[12:8]);
		end

		// Last result is due one cycle on, then watch for a stray pulse
		repeat (3) idle_cycle();

		if (exp_q.size() != 0) begin
			abort_run("Operations were still waiting for a result at the end of the run");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
source/alu_data_pkg.sv
source/alu_op_pkg.sv
source/alu_operand_if.sv
source/add_sub_unit.sv
source/logic_shift_unit.sv
source/result_stage.sv
source/alu_top.sv
+incdir+bench
bench/alu_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the ALU testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns -f flist.f --top-module alu_tb -Mdir obj_dir
	@out="$$(./obj_dir/Valu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
